//--- flist.f
source/spi_proto_pkg.sv
source/spi_regmap_pkg.sv
source/spi_tx_if.sv
source/spi_reg_if.sv
source/spi_slave_rx.sv
source/spi_slave_tx.sv
source/spi_slave_controller.sv
source/spi_slave_regs.sv
source/spi_slave_top.sv
tb/tb_spi_slave.sv

//--- Bender.yml
package:
  name: spi_slave_target

sources:
  - files:
      - source/spi_proto_pkg.sv
      - source/spi_regmap_pkg.sv
      - source/spi_tx_if.sv
      - source/spi_reg_if.sv
      - source/spi_slave_rx.sv
      - source/spi_slave_tx.sv
      - source/spi_slave_controller.sv
      - source/spi_slave_regs.sv
      - source/spi_slave_top.sv
  - target: test
    files:
      - tb/tb_spi_slave.sv

//--- tb/tb_spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the spi slave register target
// a master model drives frames, a register model predicts every miso bit
module tb_spi_slave;

  // identification word as the register map defines it
  localparam logic [31:0] id_expected = 32'h5350_4901;

  // inputs move this long after each rising edge
  localparam time drive_delay = 10ns;

  // frames and words issued by the stimulus below, used to size the watchdog
  localparam int frame_count    = 23;
  localparam int word_count     = 42;
  localparam int timeout_cycles = 2 * (3 + frame_count * (41 + 2) + 32 * word_count);

  logic sclk_test;
  logic cs;
  logic mosi;
  logic miso;

  // expected miso for the current cycle, only compared while expect_on is set
  logic expect_on;
  logic exp_bit;
  logic check_en;

  logic [31:0] model [0:7];
  logic [31:0] rng_state;

  spi_slave_top UUT (
    .sclk_test (sclk_test),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso)
  );

  initial begin
    sclk_test = 1'b0;
    forever #50 sclk_test = ~sclk_test;
  end

  // prints the fail line and ends the run
  task automatic fail_run();
    $display("Test failures found");
    $fatal(1, "run stopped after the first failing check");
  endtask

  // numerical recipes constants, full 32 bit period
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_word(output logic [31:0] value);
    rng_state = lcg_next(rng_state);
    value     = rng_state;
  endtask

  // wait for the next rising edge and step past it to the drive point
  task automatic next_edge();
    @(posedge sclk_test);
    #drive_delay;
  endtask

  // drops cs and shifts the command byte, msb first
  // returns at the drive point after edge 7 with bit 0 on mosi
  task automatic open_frame(input logic [7:0] cmd);
    int b;
    cs        = 1'b0;
    expect_on = 1'b0;
    mosi      = cmd[7];
    for (b = 6; b >= 0; b--) begin
      next_edge();
      mosi = cmd[b];
    end
  endtask

  // raising cs aborts or ends the frame, then the bus idles for two cycles
  task automatic close_frame();
    cs        = 1'b1;
    mosi      = 1'b0;
    expect_on = 1'b0;
    next_edge();
    next_edge();
  endtask

  // write frame with whole words, then tail_bits of one more word before cs rises
  // only the whole words reach the model, the cut word must be lost
  task automatic cut_write_frame(input logic [2:0] addr, input int words_n, input int tail_bits);
    logic [31:0] words [0:15];
    logic [31:0] junk;
    logic [2:0]  cur;
    int          i;
    int          j;
    draw_word(junk);
    for (j = 0; j <= words_n; j++) begin
      draw_word(words[j]);
    end
    // bits 6..3 of the command carry junk that the slave has to ignore
    open_frame({1'b1, junk[6:3], addr});
    for (j = 0; j < words_n; j++) begin
      for (i = 31; i >= 0; i--) begin
        next_edge();
        mosi = words[j][i];
      end
    end
    for (i = 31; i > 31 - tail_bits; i--) begin
      next_edge();
      mosi = words[words_n][i];
    end
    // this edge samples the last bit that was driven
    next_edge();
    close_frame();
    // addresses wrap modulo 8 and the identification word takes no writes
    cur = addr;
    for (j = 0; j < words_n; j++) begin
      if (cur != 3'd7) begin
        model[cur] = words[j];
      end
      cur = cur + 3'd1;
    end
  endtask

  task automatic write_frame(input logic [2:0] addr, input int words_n);
    cut_write_frame(addr, words_n, 0);
  endtask

  // read frame, word 0 bit 31 shows on miso from edge 9 and words follow with no gap
  task automatic read_frame(input logic [2:0] addr, input int words_n);
    logic [31:0] junk;
    logic [2:0]  cur;
    int          i;
    int          j;
    draw_word(junk);
    open_frame({1'b0, junk[6:3], addr});
    // edge 8 completes the command and miso is still low in the following cycle
    next_edge();
    mosi = 1'b0;
    cur  = addr;
    for (j = 0; j < words_n; j++) begin
      for (i = 31; i >= 0; i--) begin
        next_edge();
        expect_on = 1'b1;
        exp_bit   = model[cur][i];
      end
      cur = cur + 3'd1;
    end
    // the master samples the last bit at this edge
    next_edge();
    close_frame();
  endtask

  // bits of a read stream must match the model
  miso_follows_model : assert property (
    @(posedge sclk_test) disable iff (!check_en)
    expect_on |-> (miso == exp_bit)
  ) else begin
    $display("ERR at %0t: miso is %b but the model expects %b",
             $time, $sampled(miso), $sampled(exp_bit));
    fail_run();
  end

  // command phase, write frames and idle time keep miso low
  miso_quiet : assert property (
    @(posedge sclk_test) disable iff (!check_en)
    !expect_on |-> (miso == 1'b0)
  ) else begin
    $display("ERR at %0t: miso is %b outside a read stream", $time, $sampled(miso));
    fail_run();
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge sclk_test);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
    fail_run();
  end

  initial begin : stimulus
    int a;
    cs        = 1'b1;
    mosi      = 1'b0;
    expect_on = 1'b0;
    exp_bit   = 1'b0;
    check_en  = 1'b0;
    rng_state = 32'hc083db73;
    model[7]  = id_expected;

    // cs high for three cycles puts every frame flop into its idle state
    repeat (3) @(posedge sclk_test);
    #drive_delay;
    check_en = 1'b1;

    // single words into every writable register, then read each one back
    for (a = 0; a < 7; a++) begin
      write_frame(3'(a), 1);
    end
    for (a = 0; a < 7; a++) begin
      read_frame(3'(a), 1);
    end

    // the identification word is fixed and a write to it is dropped
    read_frame(3'd7, 1);
    write_frame(3'd7, 1);
    read_frame(3'd7, 1);

    // bursts that wrap past address 7
    write_frame(3'd5, 10);
    read_frame(3'd3, 9);

    // cut a frame inside its first word, then inside its second word
    cut_write_frame(3'd2, 0, 15);
    read_frame(3'd2, 1);
    cut_write_frame(3'd4, 1, 20);
    read_frame(3'd4, 2);

    // a few idle edges so the last samples are checked
    repeat (4) next_edge();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/spi_slave_top.sv
`timescale 1ns/1ps
`default_nettype none

// spi slave register target
// receiver and transmitter face the pins, the controller sits between them and the registers
module spi_slave_top #(
  parameter spi_proto_pkg::word_t id_value = spi_regmap_pkg::id_value_default
) (
  input  logic sclk_test,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  // receiver output toward the controller
  spi_proto_pkg::word_t rx_data;
  logic                 rx_ready;

  spi_tx_if  tx_bus ();
  spi_reg_if reg_bus ();

  spi_slave_rx u_rx (
    .sclk_test (sclk_test),
    .cs        (cs),
    .mosi      (mosi),
    .rx_data   (rx_data),
    .rx_ready  (rx_ready)
  );

  spi_slave_tx u_tx (
    .sclk_test (sclk_test),
    .cs        (cs),
    .miso      (miso),
    .tx        (tx_bus.transmitter)
  );

  spi_slave_controller u_controller (
    .sclk_test (sclk_test),
    .cs        (cs),
    .rx_data   (rx_data),
    .rx_ready  (rx_ready),
    .tx        (tx_bus.controller),
    .regs      (reg_bus.controller)
  );

  // the identification value is fixed per instance
  spi_slave_regs #(
    .id_value (id_value)
  ) u_regs (
    .sclk_test (sclk_test),
    .regs      (reg_bus.register)
  );

endmodule

`default_nettype wire

//--- source/spi_slave_regs.sv
`timescale 1ns/1ps
`default_nettype none

// eight word register file
// the last address is the read-only identification word
module spi_slave_regs #(
  parameter spi_proto_pkg::word_t id_value = spi_regmap_pkg::id_value_default
) (
  input  logic        sclk_test,
  spi_reg_if.register regs
);

  // contents persist across frames, cs only frames transactions
  spi_proto_pkg::word_t mem [spi_regmap_pkg::num_regs];

  // writes to the identification address are dropped
  always_ff @(posedge sclk_test) begin
    if (regs.we && (regs.addr != spi_regmap_pkg::id_addr)) begin
      mem[regs.addr] <= regs.wdata;
    end
  end

  // zero latency read, the transmitter takes it in the same cycle
  assign regs.rdata = (regs.addr == spi_regmap_pkg::id_addr) ? id_value : mem[regs.addr];

  // the controller must never hand over a write with an undriven address
  a_we_addr_known : assert property (
    @(posedge sclk_test)
    regs.we |-> !$isunknown(regs.addr)
  );

endmodule

`default_nettype wire

//--- source/spi_slave_controller.sv
`timescale 1ns/1ps
`default_nettype none

// frame state machine
// decodes the command byte, then steers received words into the register file
// or feeds register contents to the transmitter
module spi_slave_controller (
  input  logic                 sclk_test,
  input  logic                 cs,
  input  spi_proto_pkg::word_t rx_data,
  input  logic                 rx_ready,
  spi_tx_if.controller         tx,
  spi_reg_if.controller        regs
);

  typedef enum logic [1:0] {
    cmd,
    write,
    read
  } ctrl_state_t;

  ctrl_state_t               state_q;
  ctrl_state_t               state_d;
  spi_regmap_pkg::reg_addr_t addr_q;
  spi_regmap_pkg::reg_addr_t addr_d;

  // set after the first read cycle, so start fires once per frame
  logic                      started_q;
  logic                      started_d;

  // the command byte sits in the low bits of the receiver output
  spi_proto_pkg::cmd_t       cmd_byte;

  assign cmd_byte = rx_data[spi_proto_pkg::cmd_bits-1:0];

  // the register file always sees the current address
  assign regs.addr  = addr_q;
  assign regs.wdata = rx_data;

  // read data goes straight to the transmitter, it is only taken with data_valid
  assign tx.data = regs.rdata;

  always_comb begin
    state_d       = state_q;
    addr_d        = addr_q;
    started_d     = started_q;
    tx.start      = 1'b0;
    tx.data_valid = 1'b0;
    regs.we       = 1'b0;

    case (state_q)
      cmd: begin
        // take the start address and direction from the completed command byte
        if (rx_ready) begin
          addr_d = cmd_byte[spi_proto_pkg::cmd_addr_lsb +: $bits(spi_regmap_pkg::reg_addr_t)];
          if (cmd_byte[spi_proto_pkg::cmd_write_bit]) begin
            state_d = write;
          end else begin
            state_d = read;
          end
        end
      end

      write: begin
        // each completed word goes to the current address, the address then wraps forward
        if (rx_ready) begin
          regs.we = 1'b1;
          addr_d  = addr_q + 1'b1;
        end
      end

      read: begin
        // first cycle opens the stream with word 0, after that each done pulls the next word
        tx.start  = !started_q;
        started_d = 1'b1;
        if (!started_q || tx.done) begin
          tx.data_valid = 1'b1;
          addr_d        = addr_q + 1'b1;
        end
      end

      default: begin
        state_d = cmd;
      end
    endcase
  end

  always_ff @(posedge sclk_test or posedge cs) begin
    if (cs) begin
      state_q   <= cmd;
      addr_q    <= '0;
      started_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      addr_q    <= addr_d;
      started_q <= started_d;
    end
  end

  // start may only follow the edge where the receiver completed a command
  a_start_after_cmd : assert property (
    @(posedge sclk_test) disable iff (cs)
    tx.start |-> ($past(state_q) == cmd) && $past(rx_ready)
  );

endmodule

`default_nettype wire

//--- source/spi_slave_tx.sv
`timescale 1ns/1ps
`default_nettype none

// transmit shifter for miso
// loads a word and shifts it out msb first, a load in the done cycle keeps the stream going
module spi_slave_tx (
  input  logic                  sclk_test,
  input  logic                  cs,
  output logic                  miso,
  spi_tx_if.transmitter         tx
);

  // every word is a full data word, so the bit target never changes
  localparam spi_proto_pkg::bit_count_t counter_trgt =
    spi_proto_pkg::bit_count_t'(spi_proto_pkg::word_bits - 1);

  spi_proto_pkg::word_t       data_int;
  spi_proto_pkg::word_t       data_int_next;
  spi_proto_pkg::bit_count_t  counter;
  spi_proto_pkg::bit_count_t  counter_next;
  logic                       running;
  logic                       running_next;

  // the top bit of the shifter is what the master sees
  assign miso = data_int[spi_proto_pkg::word_bits-1];

  // last bit of the current word is on miso in this cycle
  assign tx.done = running && (counter == counter_trgt);

  always_comb begin
    // start opens the stream, it only closes when a word ends without a reload
    if (tx.start) begin
      running_next = 1'b1;
    end else if (tx.done && !tx.data_valid) begin
      running_next = 1'b0;
    end else begin
      running_next = running;
    end

    // the counter sits at zero in the start cycle, so the first load lines up with bit 31
    if (running) begin
      if (tx.done) begin
        counter_next = '0;
      end else begin
        counter_next = counter + 1'b1;
      end
    end else begin
      counter_next = counter;
    end

    if (tx.data_valid) begin
      data_int_next = tx.data;
    end else if (running) begin
      // zero fill keeps miso low once a stream runs dry
      data_int_next = {data_int[spi_proto_pkg::word_bits-2:0], 1'b0};
    end else begin
      data_int_next = data_int;
    end
  end

  always_ff @(posedge sclk_test or posedge cs) begin
    if (cs) begin
      counter  <= '0;
      data_int <= '0;
      running  <= 1'b0;
    end else begin
      counter  <= counter_next;
      data_int <= data_int_next;
      running  <= running_next;
    end
  end

  // a load anywhere else would cut a word short on the wire
  a_load_aligned : assert property (
    @(posedge sclk_test) disable iff (cs)
    tx.data_valid |-> (tx.start || tx.done)
  );

endmodule

`default_nettype wire

//--- source/spi_slave_rx.sv
`timescale 1ns/1ps
`default_nettype none

// receive shifter for mosi
// the first item after cs falls is the 8 bit command, every item after it is a 32 bit word
module spi_slave_rx (
  input  logic                 sclk_test,
  input  logic                 cs,
  input  logic                 mosi,
  output spi_proto_pkg::word_t rx_data,
  output logic                 rx_ready
);

  spi_proto_pkg::word_t       shift_q;
  spi_proto_pkg::bit_count_t  count_q;
  spi_proto_pkg::bit_count_t  target;

  // set once the command byte has been collected in this frame
  logic                       cmd_seen_q;

  // the command is short, all later items are full words
  assign target = cmd_seen_q ? spi_proto_pkg::bit_count_t'(spi_proto_pkg::word_bits - 1)
                             : spi_proto_pkg::bit_count_t'(spi_proto_pkg::cmd_bits - 1);

  // the item as it will look after this edge, so the consumer can take it right away
  // during the command phase the byte lands in the low 8 bits
  assign rx_data = {shift_q[spi_proto_pkg::word_bits-2:0], mosi};

  // high in the cycle whose closing edge samples the last bit of the item
  assign rx_ready = (count_q == target);

  always_ff @(posedge sclk_test or posedge cs) begin
    if (cs) begin
      shift_q    <= '0;
      count_q    <= '0;
      cmd_seen_q <= 1'b0;
    end else begin
      shift_q <= rx_data;
      if (rx_ready) begin
        // wrap and switch over to full words after the command
        count_q    <= '0;
        cmd_seen_q <= 1'b1;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // every item is at least 8 bits long, so two strobes in a row mean the counter is broken
  a_rx_ready_single : assert property (
    @(posedge sclk_test) disable iff (cs)
    rx_ready |=> !rx_ready
  );

endmodule

`default_nettype wire

//--- source/spi_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// link between the frame controller and the register file
interface spi_reg_if;

  // current register address, used for both writes and reads
  spi_regmap_pkg::reg_addr_t addr;

  // write data and its one-cycle strobe, committed on the same edge
  spi_proto_pkg::word_t      wdata;
  logic                      we;

  // read data, returned combinationally from addr
  spi_proto_pkg::word_t      rdata;

  modport controller (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  modport register (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

`default_nettype wire

//--- source/spi_tx_if.sv
`timescale 1ns/1ps
`default_nettype none

// link between the frame controller and the transmit shifter
interface spi_tx_if;

  // one-cycle strobe that opens a read stream
  logic                 start;

  // next word to shift out, taken when data_valid is high
  spi_proto_pkg::word_t data;
  logic                 data_valid;

  // high while the last bit of the current word is on miso
  // the controller answers it with data_valid in the same cycle so words stream gap free
  logic                 done;

  modport controller (
    output start,
    output data,
    output data_valid,
    input  done
  );

  modport transmitter (
    input  start,
    input  data,
    input  data_valid,
    output done
  );

endinterface

`default_nettype wire

//--- source/spi_regmap_pkg.sv
`default_nettype none

// register map of the slave target
// seven read/write words followed by one read-only identification word
package spi_regmap_pkg;

  // number of addressable words, the address wraps modulo this count
  localparam int unsigned num_regs = 8;

  // register address as carried by the command byte
  typedef logic [$clog2(num_regs)-1:0] reg_addr_t;

  // the identification word sits at the last address
  localparam reg_addr_t id_addr = 3'd7;

  // value returned by the identification word unless the top level overrides it
  localparam spi_proto_pkg::word_t id_value_default = 32'h5350_4901;

endpackage

`default_nettype wire

//--- source/spi_proto_pkg.sv
`default_nettype none

// shared definitions for the spi wire protocol itself
// everything that describes how bits are framed on mosi and miso lives here
package spi_proto_pkg;

  // every data word on the wire is this wide, sent msb first
  localparam int unsigned word_bits = 32;

  // the command byte that opens each frame
  localparam int unsigned cmd_bits = 8;

  // bit 7 of the command byte selects a write when set and a read when clear
  localparam int unsigned cmd_write_bit = 7;

  // the start register address sits in the lowest command bits
  localparam int unsigned cmd_addr_lsb = 0;

  // one data word as it is shifted in or out
  typedef logic [word_bits-1:0] word_t;

  // the command byte as received
  typedef logic [cmd_bits-1:0] cmd_t;

  // position counter inside a word, wide enough to count up to word_bits - 1
  typedef logic [$clog2(word_bits)-1:0] bit_count_t;

endpackage

`default_nettype wire
